//--- logic/exec_pkg.sv
package exec_pkg;

    // ####################
    // widths
    localparam int xlen       = 32;
    localparam int ilen       = 32;
    localparam int reg_count  = 32;
    localparam int reg_addr_w = $clog2(reg_count);

    // ####################
    // instruction word layout
    localparam int op_hi       = 31;
    localparam int op_lo       = 28;
    localparam int rd_hi       = 27;
    localparam int rd_lo       = 23;
    localparam int rs1_hi      = 22;
    localparam int rs1_lo      = 18;
    localparam int rs2_hi      = 17;
    localparam int rs2_lo      = 13;
    localparam int use_imm_bit = 12;
    localparam int imm_hi      = 11;
    localparam int imm_lo      = 0;
    localparam int imm_w       = imm_hi - imm_lo + 1;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [ilen-1:0]       instr_t;

    // opcodes 9 to 15 are illegal
    typedef enum logic [3:0] {
        fop_add = 4'd0,
        fop_sub = 4'd1,
        fop_sll = 4'd2,
        fop_srl = 4'd3,
        fop_sra = 4'd4,
        fop_and = 4'd5,
        fop_or  = 4'd6,
        fop_xor = 4'd7,
        fop_imm = 4'd8
    } fop_t;

    // ####################
    // stage payloads
    typedef struct packed {
        logic      valid;
        fop_t      fop;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_imm;
        word_t     imm;
    } decoded_t;

    typedef struct packed {
        logic      valid;
        fop_t      fop;
        reg_addr_t rd;
        word_t     a;
        word_t     b;
    } operands_t;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     value;
    } bypass_t;

endpackage

//--- logic/instr_decode.sv
`timescale 1ns/100ps

module instr_decode (
    input  logic               clk,
    input  logic               reset,
    input  logic               instr_valid,
    input  exec_pkg::instr_t   instr,
    output exec_pkg::decoded_t dec,
    output logic               illegal
);

    import exec_pkg::*;

    logic [op_hi-op_lo:0] opcode;
    logic                 legal;
    word_t                imm_ext;

    assign opcode = instr[op_hi:op_lo];

    // anything past imm has no operation behind it
    assign legal = (opcode <= fop_imm);

    assign imm_ext = {{(xlen-imm_w){instr[imm_hi]}}, instr[imm_hi:imm_lo]};

    always_ff @(posedge clk) begin
        if (reset) begin
            dec.valid <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            dec.valid <= instr_valid && legal;
            illegal   <= instr_valid && !legal;
        end

        // fields only matter when valid
        if (instr_valid) begin
            dec.fop     <= fop_t'(opcode);
            dec.rd      <= instr[rd_hi:rd_lo];
            dec.rs1     <= instr[rs1_hi:rs1_lo];
            dec.rs2     <= instr[rs2_hi:rs2_lo];
            dec.use_imm <= instr[use_imm_bit];
            dec.imm     <= imm_ext;
        end
    end

    // a dropped instruction never goes downstream
    assert property (@(posedge clk) disable iff (reset)
        !(dec.valid && illegal))
    else $error("decode valid and illegal high together");

endmodule

//--- logic/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  exec_pkg::reg_addr_t rs1,
    input  exec_pkg::reg_addr_t rs2,
    output exec_pkg::word_t     rdata1,
    output exec_pkg::word_t     rdata2,
    input  exec_pkg::bypass_t   wr
);

    import exec_pkg::*;

    word_t regs [reg_count];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && (wr.rd != '0)) begin
            regs[wr.rd] <= wr.value;
        end
    end

    // ####################
    // read ports
    // r0 hardwired to zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- logic/operand_fetch.sv
`timescale 1ns/100ps

module operand_fetch (
    input  logic                 clk,
    input  logic                 reset,
    input  exec_pkg::decoded_t   dec,
    output exec_pkg::reg_addr_t  rs1,
    output exec_pkg::reg_addr_t  rs2,
    input  exec_pkg::word_t      rdata1,
    input  exec_pkg::word_t      rdata2,
    input  exec_pkg::bypass_t    fwd,
    output exec_pkg::operands_t  ops
);

    import exec_pkg::*;

    logic  fwd_a;
    logic  fwd_b;
    word_t op_a;
    word_t op_b;

    assign rs1 = dec.rs1;
    assign rs2 = dec.rs2;

    // ####################
    // forwarding from execute
    // writes to r0 are dropped, so never forward them
    assign fwd_a = fwd.valid && (fwd.rd != '0) && (fwd.rd == dec.rs1);
    assign fwd_b = fwd.valid && (fwd.rd != '0) && (fwd.rd == dec.rs2);

    assign op_a = fwd_a ? fwd.value : rdata1;

    always_comb begin
        if (dec.use_imm) begin
            op_b = dec.imm;
        end else if (fwd_b) begin
            op_b = fwd.value;
        end else begin
            op_b = rdata2;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ops.valid <= 1'b0;
        end else begin
            ops.valid <= dec.valid;
        end

        if (dec.valid) begin
            ops.fop <= dec.fop;
            ops.rd  <= dec.rd;
            ops.a   <= op_a;
            ops.b   <= op_b;
        end
    end

    // decode filters bad opcodes, so execute only sees known ones
    assert property (@(posedge clk) disable iff (reset)
        ops.valid |-> (!$isunknown(ops.fop) && (ops.fop <= fop_imm)))
    else $error("unknown fop reached execute");

endmodule

//--- logic/alu.sv
`timescale 1ns/100ps

module alu (
    input  exec_pkg::fop_t   fop,
    input  exec_pkg::word_t  a,
    input  exec_pkg::word_t  b,
    output exec_pkg::word_t  result,
    output exec_pkg::flags_t flags
);

    import exec_pkg::*;

    logic [4:0]  shamt;
    logic [xlen:0] sum;
    logic [xlen:0] diff;

    // only the low 5 bits count as a shift amount
    assign shamt = b[4:0];

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    always_comb begin
        flags.c = 1'b0;
        flags.v = 1'b0;
        case (fop)
            fop_add: begin
                result  = sum[xlen-1:0];
                flags.c = sum[xlen];
                flags.v = (a[xlen-1] == b[xlen-1]) && (result[xlen-1] != a[xlen-1]);
            end
            fop_sub: begin
                result  = diff[xlen-1:0];
                // set when a >= b unsigned
                flags.c = !diff[xlen];
                flags.v = (a[xlen-1] != b[xlen-1]) && (result[xlen-1] != a[xlen-1]);
            end
            fop_sll: result = a << shamt;
            fop_srl: result = a >> shamt;
            fop_sra: result = $signed(a) >>> shamt;
            fop_and: result = a & b;
            fop_or:  result = a | b;
            fop_xor: result = a ^ b;
            fop_imm: result = b;
            default: result = '0;
        endcase
        flags.z = (result == '0);
        flags.n = result[xlen-1];
    end

endmodule

//--- logic/alu_stage.sv
`timescale 1ns/100ps

module alu_stage (
    input  logic                clk,
    input  logic                reset,
    input  exec_pkg::operands_t ops,
    output exec_pkg::bypass_t   fwd,
    output logic                result_valid,
    output exec_pkg::word_t     result,
    output exec_pkg::reg_addr_t result_rd,
    output exec_pkg::flags_t    flags
);

    import exec_pkg::*;

    word_t  alu_result;
    flags_t alu_flags;

    alu u_alu (
        .fop    (ops.fop),
        .a      (ops.a),
        .b      (ops.b),
        .result (alu_result),
        .flags  (alu_flags)
    );

    // same-cycle value for write-back and forwarding
    assign fwd.valid = ops.valid;
    assign fwd.rd    = ops.rd;
    assign fwd.value = alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            flags        <= '0;
        end else begin
            result_valid <= ops.valid;
            flags        <= ops.valid ? alu_flags : '0;
        end

        if (ops.valid) begin
            result    <= alu_result;
            result_rd <= ops.rd;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        result_valid |-> !$isunknown(result))
    else $error("result has unknown bits while valid");

endmodule

//--- logic/exec_pipe.sv
`timescale 1ns/100ps

module exec_pipe (
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  exec_pkg::instr_t    instr,
    output logic                result_valid,
    output exec_pkg::word_t     result,
    output exec_pkg::reg_addr_t result_rd,
    output exec_pkg::flags_t    flags,
    output logic                illegal
);

    import exec_pkg::*;

    decoded_t  dec;
    operands_t ops;
    bypass_t   fwd;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rdata1;
    word_t     rdata2;

    // ####################
    // decode, operand fetch, execute
    instr_decode u_instr_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec         (dec),
        .illegal     (illegal)
    );

    operand_fetch u_operand_fetch (
        .clk    (clk),
        .reset  (reset),
        .dec    (dec),
        .rs1    (rs1_addr),
        .rs2    (rs2_addr),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .fwd    (fwd),
        .ops    (ops)
    );

    // write port fed straight from execute
    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .rs1    (rs1_addr),
        .rs2    (rs2_addr),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wr     (fwd)
    );

    alu_stage u_alu_stage (
        .clk          (clk),
        .reset        (reset),
        .ops          (ops),
        .fwd          (fwd),
        .result_valid (result_valid),
        .result       (result),
        .result_rd    (result_rd),
        .flags        (flags)
    );

endmodule

//--- bench/exec_pipe_tb.sv
`timescale 1ns/100ps

module exec_pipe_tb;

    import exec_pkg::*;

    localparam int cycle_limit  = 2000;
    localparam int random_count = 500;

    typedef struct packed {
        int unsigned cycle;
        reg_addr_t   rd;
        word_t       result;
        flags_t      flags;
    } expect_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        instr_valid;
    instr_t      instr;
    logic        result_valid;
    word_t       result;
    reg_addr_t   result_rd;
    flags_t      flags;
    logic        illegal;
    logic        issue_good;
    logic        issue_bad;

    word_t       model_regs [reg_count];
    expect_t     exp_q [$];
    int unsigned ill_q [$];
    expect_t     cur = '0;
    int unsigned ill_stamp = 0;
    int unsigned cycle_cnt = 0;
    int unsigned reset_edges = 0;

    exec_pipe u_exec_pipe (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result       (result),
        .result_rd    (result_rd),
        .flags        (flags),
        .illegal      (illegal)
    );

    always #5 clk = ~clk;

    task automatic stop_with_fail();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped on the first error");
    endtask

    always @(posedge clk) begin
        if (reset) begin
            reset_edges <= reset_edges + 1;
        end
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout, the run went past %0d cycles", cycle_limit);
            stop_with_fail();
        end
    end

    // ####################
    // reference model
    function automatic void model_alu(input logic [3:0] op, input word_t a, input word_t b,
                                      output word_t r, output flags_t f);
        longint wide;
        logic [4:0] sh;
        sh = b[4:0];
        f  = '0;
        case (op)
            4'd0: begin
                r    = a + b;
                wide = longint'($signed(a)) + longint'($signed(b));
                f.c  = (r < a);
                f.v  = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
            end
            4'd1: begin
                r    = a - b;
                wide = longint'($signed(a)) - longint'($signed(b));
                f.c  = (a >= b);
                f.v  = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
            end
            4'd2:    r = a << sh;
            4'd3:    r = a >> sh;
            4'd4:    r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            4'd5:    r = a & b;
            4'd6:    r = a | b;
            4'd7:    r = a ^ b;
            default: r = b;
        endcase
        f.z = (r == 32'h0);
        f.n = r[31];
    endfunction

    function automatic instr_t make_instr(input logic [3:0] op, input reg_addr_t rd,
                                          input reg_addr_t rs1, input reg_addr_t rs2,
                                          input logic use_imm, input logic [11:0] imm);
        return {op, rd, rs1, rs2, use_imm, imm};
    endfunction

    // small register window so dependencies come up often
    function automatic instr_t random_instr();
        logic [3:0] op;
        if ($urandom_range(0, 19) == 0) begin
            op = 4'($urandom_range(9, 15));
        end else begin
            op = 4'($urandom_range(0, 8));
        end
        return make_instr(op, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)),
                          5'($urandom_range(0, 7)), ($urandom_range(0, 3) == 0),
                          12'($urandom));
    endfunction

    task automatic issue(input instr_t w);
        logic [3:0] op;
        reg_addr_t  rd;
        word_t      a;
        word_t      b;
        word_t      res;
        flags_t     flg;
        expect_t    e;
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = w;
        op          = w[op_hi:op_lo];
        rd          = w[rd_hi:rd_lo];
        if (op > 4'd8) begin
            ill_q.push_back(cycle_cnt);
        end else begin
            a = model_regs[w[rs1_hi:rs1_lo]];
            if (w[use_imm_bit]) begin
                b = {{20{w[imm_hi]}}, w[imm_hi:imm_lo]};
            end else begin
                b = model_regs[w[rs2_hi:rs2_lo]];
            end
            model_alu(op, a, b, res, flg);
            e.cycle  = cycle_cnt;
            e.rd     = rd;
            e.result = res;
            e.flags  = flg;
            exp_q.push_back(e);
            // r0 keeps its zero
            if (rd != '0) begin
                model_regs[rd] = res;
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    // ####################
    // checks
    assign issue_good = instr_valid && (instr[op_hi:op_lo] <= 4'd8);
    assign issue_bad  = instr_valid && (instr[op_hi:op_lo] > 4'd8);

    always @(negedge clk) begin
        if (!reset && result_valid) begin
            if (exp_q.size() == 0) begin
                $display("result_valid came with no result pending");
                stop_with_fail();
            end else begin
                cur = exp_q.pop_front();
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && illegal) begin
            if (ill_q.size() == 0) begin
                $display("illegal pulse came with no illegal opcode pending");
                stop_with_fail();
            end else begin
                ill_stamp = ill_q.pop_front();
            end
        end
    end

    assert property (@(posedge clk)
        (reset && reset_edges > 0) |-> (!result_valid && !illegal && flags == '0))
    else begin
        $display("outputs were not cleared during reset");
        stop_with_fail();
    end

    assert property (@(posedge clk) disable iff (reset) issue_good |-> ##3 result_valid)
    else begin
        $display("no result 3 cycles after a legal issue");
        stop_with_fail();
    end

    assert property (@(posedge clk) disable iff (reset) result_valid |-> $past(issue_good, 3))
    else begin
        $display("result_valid without a legal issue 3 cycles before");
        stop_with_fail();
    end

    assert property (@(posedge clk) disable iff (reset) issue_bad |-> ##1 illegal)
    else begin
        $display("no illegal pulse 1 cycle after an illegal opcode");
        stop_with_fail();
    end

    assert property (@(posedge clk) disable iff (reset) illegal |-> $past(issue_bad))
    else begin
        $display("illegal pulse without an illegal opcode");
        stop_with_fail();
    end

    assert property (@(posedge clk) disable iff (reset)
        result_valid |-> ($sampled(cycle_cnt) == cur.cycle + 3))
    else begin
        $display("FAIL %0t issue_cycle got %0d expected %0d", $time,
                 $sampled(cycle_cnt) - 3, cur.cycle);
        stop_with_fail();
    end

    assert property (@(posedge clk) disable iff (reset) result_valid |-> result == cur.result)
    else begin
        $display("FAIL %0t result got %h expected %h", $time, $sampled(result), cur.result);
        stop_with_fail();
    end

    assert property (@(posedge clk) disable iff (reset) result_valid |-> result_rd == cur.rd)
    else begin
        $display("FAIL %0t result_rd got %0d expected %0d", $time, $sampled(result_rd), cur.rd);
        stop_with_fail();
    end

    assert property (@(posedge clk) disable iff (reset) result_valid |-> flags == cur.flags)
    else begin
        $display("FAIL %0t flags got %b expected %b", $time, $sampled(flags), cur.flags);
        stop_with_fail();
    end

    // flags stay clear between results
    assert property (@(posedge clk) disable iff (reset) !result_valid |-> flags == '0)
    else begin
        $display("FAIL %0t flags got %b expected %b", $time, $sampled(flags), 4'b0000);
        stop_with_fail();
    end

    assert property (@(posedge clk) disable iff (reset)
        illegal |-> ($sampled(cycle_cnt) == ill_stamp + 1))
    else begin
        $display("FAIL %0t illegal_cycle got %0d expected %0d", $time,
                 $sampled(cycle_cnt) - 1, ill_stamp);
        stop_with_fail();
    end

    // ####################
    // stimulus
    initial begin
        void'($urandom(32'hf08f_21a6));
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // every register reads zero after reset
        for (int i = 0; i < reg_count; i++) begin
            issue(make_instr(4'd6, 5'(i), 5'(i), 5'(i), 1'b0, 12'h0));
        end

        // corner operands in r1 to r4
        issue(make_instr(4'd8, 5'd1, 5'd0, 5'd0, 1'b1, 12'hfff));
        issue(make_instr(4'd8, 5'd2, 5'd0, 5'd0, 1'b1, 12'h001));
        issue(make_instr(4'd2, 5'd3, 5'd2, 5'd0, 1'b1, 12'd31));
        issue(make_instr(4'd7, 5'd4, 5'd1, 5'd3, 1'b0, 12'h0));
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                issue(make_instr(4'd0, 5'd31, 5'(i), 5'(j), 1'b0, 12'h0));
                issue(make_instr(4'd1, 5'd30, 5'(i), 5'(j), 1'b0, 12'h0));
            end
        end

        // r0 ignores writes
        issue(make_instr(4'd8, 5'd0, 5'd0, 5'd0, 1'b1, 12'h5a5));
        issue(make_instr(4'd0, 5'd5, 5'd0, 5'd0, 1'b0, 12'h0));
        issue(make_instr(4'd6, 5'd6, 5'd0, 5'd1, 1'b0, 12'h0));

        // consumer at distance 1, 2 and 3
        for (int d = 1; d <= 3; d++) begin
            issue(make_instr(4'd8, 5'd7, 5'd0, 5'd0, 1'b1, 12'(d * 100)));
            repeat (d - 1) issue(make_instr(4'd7, 5'd8, 5'd8, 5'd2, 1'b0, 12'h0));
            issue(make_instr(4'd0, 5'd9, 5'd7, 5'd7, 1'b0, 12'h0));
        end

        // dropped opcode leaves r7 alone
        issue(make_instr(4'd12, 5'd7, 5'd1, 5'd1, 1'b0, 12'h0));
        issue(make_instr(4'd6, 5'd10, 5'd7, 5'd0, 1'b0, 12'h0));

        // full rate stream and then random gaps
        for (int n = 0; n < random_count; n++) begin
            issue(random_instr());
            if (n >= random_count / 2) begin
                idle($urandom_range(0, 3));
            end
        end
        idle(1);

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        idle(3);
        if (ill_q.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("expected illegal pulses never arrived");
            stop_with_fail();
        end
    end

endmodule

//--- all.f
logic/exec_pkg.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/operand_fetch.sv
logic/alu.sv
logic/alu_stage.sv
logic/exec_pipe.sv
bench/exec_pipe_tb.sv

//--- Bender.yml
package:
  name: exec_pipe

sources:
  - logic/exec_pkg.sv
  - logic/instr_decode.sv
  - logic/reg_file.sv
  - logic/operand_fetch.sv
  - logic/alu.sv
  - logic/alu_stage.sv
  - logic/exec_pipe.sv
  - target: test
    files:
      - bench/exec_pipe_tb.sv
